// ==== all.f ====
lcdPkg.sv
modeDecoder.sv
bcdConverter.sv
valueScaler.sv
screenComposer.sv
lcdSequencer.sv
solarLcd.sv
tb_solarLcd.sv

// ==== bcdConverter.sv ====
/* Registered binary to three ASCII decimal digits */
`timescale 1ns/100ps

module bcdConverter import lcdPkg::*; #(
   parameter type valueT = centiVolt_t
) (
   input  logic     CLK,
   input  valueT    value,
   output digits3_t digits
);

   logic [9:0] bin;    // Widened copy holding up to 999
   logic [3:0] hund;
   logic [3:0] tens;
   logic [3:0] ones;

   // --------------------
   // Digit split
   always_comb begin
      bin  = 10'(value);
      hund = 4'(bin / 10'd100);
      tens = 4'((bin / 10'd10) % 10'd10);
      ones = 4'(bin % 10'd10);
   end

   // --------------------
   // ASCII offset and output register
   always_ff @(posedge CLK) begin
      digits.hundreds <= CHAR_ZERO + lcdChar_t'(hund);
      digits.tens     <= CHAR_ZERO + lcdChar_t'(tens);
      digits.ones     <= CHAR_ZERO + lcdChar_t'(ones);
   end

endmodule

// ==== lcdPkg.sv ====
/* Widths, payload types, grouped structs and display mode enum,
   plus scaling constants and HD44780 command and character codes */
package lcdPkg;

   // --------------------
   // Widths and scalar types
   localparam int ADC_WIDTH   = 12;
   localparam int PULSE_WIDTH = 32;

   typedef logic [ADC_WIDTH-1:0]   adcSample_t;
   typedef logic [PULSE_WIDTH-1:0] pulseWidth_t;   // Servo high time in us
   typedef logic [8:0]             centiVolt_t;    // 0 to 330
   typedef logic [7:0]             angleDeg_t;     // 0 to 180
   typedef logic [7:0]             lcdChar_t;

   // --------------------
   // Grouped signals
   typedef struct packed {
      pulseWidth_t horiz;
      pulseWidth_t vert;
   } servoPair_t;

   typedef struct packed {
      logic horizSweep;
      logic vertSweep;
      logic manualCal;
   } sweepFlags_t;

   typedef enum logic [1:0] {
      modeManual,
      modeCalib,
      modeAngle
   } dispMode_t;

   // ASCII digits with leading zeros kept
   typedef struct packed {
      lcdChar_t hundreds;
      lcdChar_t tens;
      lcdChar_t ones;
   } digits3_t;

   typedef struct packed {
      dispMode_t mode;
      digits3_t  maxVolt;
      digits3_t  nowVolt;
      digits3_t  maxH;
      digits3_t  maxV;
      digits3_t  nowH;
      digits3_t  nowV;
   } scaledValues_t;

   typedef struct packed {
      logic     rs;     // 0 command, 1 character
      logic     en;
      lcdChar_t data;
   } lcdBus_t;

   // --------------------
   // Scaling constants
   localparam int VOLT_FULL_SCALE  = 330;    // Centivolts at ADC_MAX
   localparam int ADC_MAX          = 4095;
   localparam int ANGLE_RANGE      = 180;
   localparam int PULSE_FULL_SCALE = 2500;   // High time for ANGLE_RANGE

   // --------------------
   // Panel codes
   localparam lcdChar_t CMD_FUNCTION_SET = 8'h38;   // 8-bit bus, 2 lines
   localparam lcdChar_t CMD_DISPLAY_ON   = 8'h0C;   // No cursor, no blink
   localparam lcdChar_t CMD_ENTRY_MODE   = 8'h06;   // Auto increment
   localparam lcdChar_t CMD_CLEAR        = 8'h01;
   localparam lcdChar_t CMD_ROW1         = 8'h80;
   localparam lcdChar_t CMD_ROW2         = 8'hC0;
   localparam lcdChar_t CHAR_ZERO        = 8'h30;
   localparam lcdChar_t CHAR_SPACE       = 8'h20;

endpackage

// ==== lcdSequencer.sv ====
/* Panel init and refresh loop with timed enable pulses on the 8-bit bus */
`timescale 1ns/100ps

module lcdSequencer import lcdPkg::*; #(
   parameter int ENABLE_HIGH_CYCLES = 101,
   parameter int ENABLE_LOW_CYCLES  = 99
) (
   input  logic     CLK,
   input  logic     rst,
   input  lcdChar_t screenBuf [32],
   output lcdBus_t  lcd
);

   localparam int BYTE_CYCLES = ENABLE_HIGH_CYCLES + ENABLE_LOW_CYCLES;
   localparam int PHASE_W     = $clog2(BYTE_CYCLES);
   localparam int ROW1_SLOT   = 4;    // Loop restarts here after init
   localparam int ROW2_SLOT   = 21;
   localparam int LAST_SLOT   = 37;

   logic [PHASE_W-1:0] phase;
   logic [5:0]         byteIdx;   // 0..3 init, 4..37 refresh
   lcdChar_t           nextData;
   logic               nextRs;

   // --------------------
   // Byte select
   always_comb begin
      nextRs   = 1'b0;
      nextData = CMD_CLEAR;
      case (byteIdx)
         6'd0:      nextData = CMD_FUNCTION_SET;
         6'd1:      nextData = CMD_DISPLAY_ON;
         6'd2:      nextData = CMD_ENTRY_MODE;
         6'd3:      nextData = CMD_CLEAR;
         ROW1_SLOT: nextData = CMD_ROW1;
         ROW2_SLOT: nextData = CMD_ROW2;
         default: begin
            nextRs = 1'b1;
            // Row 1 chars sit after ROW1_SLOT, row 2 chars after ROW2_SLOT
            if (byteIdx < ROW2_SLOT) nextData = screenBuf[5'(byteIdx - 6'd5)];
            else nextData = screenBuf[5'(byteIdx - 6'd6)];
         end
      endcase
   end

   // --------------------
   // Enable timing
   always_ff @(posedge CLK) begin
      if (rst) begin
         phase   <= '0;
         byteIdx <= '0;
         lcd     <= '0;
      end else begin
         if (phase == '0) begin
            lcd.rs   <= nextRs;   // Held for the whole byte
            lcd.data <= nextData;
            lcd.en   <= 1'b1;
         end else if (phase == PHASE_W'(ENABLE_HIGH_CYCLES)) begin
            lcd.en <= 1'b0;
         end

         if (phase == PHASE_W'(BYTE_CYCLES - 1)) begin
            phase   <= '0;
            byteIdx <= (byteIdx == 6'(LAST_SLOT)) ? 6'(ROW1_SLOT) : byteIdx + 6'd1;
         end else begin
            phase <= phase + 1'b1;
         end
      end
   end

endmodule

// ==== modeDecoder.sv ====
/* Decode stage with input registers and display mode priority */
`timescale 1ns/100ps

module modeDecoder import lcdPkg::*; (
   input  logic        CLK,
   input  logic        rst,
   input  logic        angleMode,
   input  sweepFlags_t sweep,
   input  adcSample_t  adcNow,
   input  adcSample_t  adcMax,
   input  servoPair_t  pulseNow,
   input  servoPair_t  pulseMax,
   output dispMode_t   mode,
   output adcSample_t  adcNowQ,
   output adcSample_t  adcMaxQ,
   output servoPair_t  pulseNowQ,
   output servoPair_t  pulseMaxQ
);

   // Angle view beats calibration and any sweep flag means calibration
   always_ff @(posedge CLK) begin
      if (rst) begin
         mode <= modeManual;
      end else if (angleMode) begin
         mode <= modeAngle;
      end else if (sweep.horizSweep || sweep.vertSweep || sweep.manualCal) begin
         mode <= modeCalib;
      end else begin
         mode <= modeManual;
      end
   end

   always_ff @(posedge CLK) begin
      adcNowQ   <= adcNow;
      adcMaxQ   <= adcMax;
      pulseNowQ <= pulseNow;
      pulseMaxQ <= pulseMax;
   end

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run with Verilator, then search the output for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_solarLcd -f all.f -o tb_solarLcd \
   && ./obj_dir/tb_solarLcd | tee /dev/stderr | grep -qx "TB PASSED" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== screenComposer.sv ====
/* Result stage filling the 2x16 screen buffer from labels and digit fields */
`timescale 1ns/100ps

module screenComposer import lcdPkg::*; (
   input  logic          CLK,
   input  logic          rst,
   input  scaledValues_t scaled,
   output lcdChar_t      screenBuf [32]
);

   typedef lcdChar_t [0:15] rowText_t;   // Index 0 is the leftmost column

   // --------------------
   // Row templates
   localparam rowText_t CALIB_TEXT  = "CALIBRATING     ";
   localparam rowText_t MANUAL_TEXT = "MANUAL CTRL     ";
   localparam rowText_t VOLT_TEXT   = "M: 0.00 V: 0.00 ";   // Digits patched in
   localparam rowText_t ANGLE_TEXT  = "H: 000D V: 000D ";

   rowText_t row1;
   rowText_t row2;

   // Voltages as d.dd with the period between hundreds and tens
   function automatic rowText_t fillVolt(digits3_t maxVal, digits3_t nowVal);
      rowText_t row;
      row     = VOLT_TEXT;
      row[3]  = maxVal.hundreds;
      row[5]  = maxVal.tens;
      row[6]  = maxVal.ones;
      row[11] = nowVal.hundreds;
      row[13] = nowVal.tens;
      row[14] = nowVal.ones;
      return row;
   endfunction

   function automatic rowText_t fillAngle(digits3_t hVal, digits3_t vVal);
      rowText_t row;
      row     = ANGLE_TEXT;
      row[3]  = hVal.hundreds;
      row[4]  = hVal.tens;
      row[5]  = hVal.ones;
      row[11] = vVal.hundreds;
      row[12] = vVal.tens;
      row[13] = vVal.ones;
      return row;
   endfunction

   // --------------------
   // Row selection per mode
   always_comb begin
      case (scaled.mode)
         modeAngle: begin
            row1 = fillAngle(scaled.maxH, scaled.maxV);   // Best irradiance
            row2 = fillAngle(scaled.nowH, scaled.nowV);
         end
         modeCalib: begin
            row1 = CALIB_TEXT;
            row2 = fillVolt(scaled.maxVolt, scaled.nowVolt);
         end
         default: begin
            row1 = MANUAL_TEXT;
            row2 = fillVolt(scaled.maxVolt, scaled.nowVolt);
         end
      endcase
   end

   always_ff @(posedge CLK) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            screenBuf[i] <= CHAR_SPACE;
         end
      end else begin
         for (int i = 0; i < 16; i++) begin
            screenBuf[i]      <= row1[i];
            screenBuf[i + 16] <= row2[i];
         end
      end
   end

endmodule

// ==== solarLcd.sv ====
/* Top level of the tracker status LCD driver */
`timescale 1ns/100ps

module solarLcd import lcdPkg::*; #(
   parameter int ENABLE_HIGH_CYCLES = 101,
   parameter int ENABLE_LOW_CYCLES  = 99
) (
   input  logic        CLK,
   input  logic        rst,
   input  logic        angleMode,
   input  sweepFlags_t sweep,
   input  adcSample_t  adcNow,
   input  adcSample_t  adcMax,
   input  servoPair_t  pulseNow,
   input  servoPair_t  pulseMax,
   output lcdBus_t     lcd
);

   dispMode_t     mode;
   adcSample_t    adcNowQ;
   adcSample_t    adcMaxQ;
   servoPair_t    pulseNowQ;
   servoPair_t    pulseMaxQ;
   scaledValues_t scaled;
   lcdChar_t      screenBuf [32];

   // --------------------
   // Three-stage pipeline into the panel driver
   modeDecoder modeDecoder_i (
      .CLK(CLK), .rst(rst), .angleMode(angleMode), .sweep(sweep),
      .adcNow(adcNow), .adcMax(adcMax), .pulseNow(pulseNow), .pulseMax(pulseMax),
      .mode(mode), .adcNowQ(adcNowQ), .adcMaxQ(adcMaxQ),
      .pulseNowQ(pulseNowQ), .pulseMaxQ(pulseMaxQ)
   );

   valueScaler valueScaler_i (
      .CLK(CLK), .rst(rst), .mode(mode),
      .adcNow(adcNowQ), .adcMax(adcMaxQ), .pulseNow(pulseNowQ), .pulseMax(pulseMaxQ),
      .scaled(scaled)
   );

   screenComposer screenComposer_i (
      .CLK(CLK), .rst(rst), .scaled(scaled), .screenBuf(screenBuf)
   );

   lcdSequencer #(
      .ENABLE_HIGH_CYCLES(ENABLE_HIGH_CYCLES),
      .ENABLE_LOW_CYCLES (ENABLE_LOW_CYCLES)
   ) lcdSequencer_i (
      .CLK(CLK), .rst(rst), .screenBuf(screenBuf), .lcd(lcd)
   );

endmodule

// ==== tb_solarLcd.sv ====
/* Testbench for the tracker LCD driver, with stimulus table, panel model,
   compare tasks and a cycle limit */
`timescale 1ns/100ps

module tb_solarLcd import lcdPkg::*; ();

   localparam int EN_HIGH     = 3;
   localparam int EN_LOW      = 3;
   localparam int NUM_TESTS   = 10;
   localparam int CYCLE_LIMIT = (NUM_TESTS + 2) * 3 * 34 * (EN_HIGH + EN_LOW);

   typedef lcdChar_t [0:15] rowText_t;   // Index 0 is the leftmost column

   typedef struct packed {
      logic        angleMode;
      sweepFlags_t sweep;
      adcSample_t  adcNow;
      adcSample_t  adcMax;
      servoPair_t  pulseNow;
      servoPair_t  pulseMax;
      rowText_t    row1;
      rowText_t    row2;
   } stimEntry_t;

   logic        CLK;
   logic        rst;
   logic        angleMode;
   sweepFlags_t sweep;
   adcSample_t  adcNow;
   adcSample_t  adcMax;
   servoPair_t  pulseNow;
   servoPair_t  pulseMax;
   lcdBus_t     lcd;

   stimEntry_t  stimTable [NUM_TESTS];
   string       testName [NUM_TESTS];
   logic [31:0] lcgState = 32'd82706;
   int          errors;
   int          passCount;
   int          failCount;
   int          cycles;

   // Panel model state
   lcdChar_t    panel [32];
   lcdChar_t    initLog [5];
   logic        initRs [5];
   lcdChar_t    lastCmd;
   logic        enPrev = 1'b0;
   int          byteCount;
   int          cursor;
   int          rowChars;      // Characters since the last address command
   int          row1Cmds;
   int          refreshDone;   // Bumped on the write to the last cell
   int          framingErrs;

   solarLcd #(.ENABLE_HIGH_CYCLES(EN_HIGH), .ENABLE_LOW_CYCLES(EN_LOW)) solarLcd_i (
      .CLK(CLK), .rst(rst), .angleMode(angleMode), .sweep(sweep), .adcNow(adcNow),
      .adcMax(adcMax), .pulseNow(pulseNow), .pulseMax(pulseMax), .lcd(lcd)
   );

   always #4 CLK = ~CLK;

   always @(posedge CLK) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
         $display("TB FAILED");
         $finish;
      end
   end

   // --------------------
   // Panel model latching rs and data as en falls
   always @(negedge CLK) begin
      if (enPrev && !lcd.en) begin
         if (byteCount < 5) begin
            initLog[byteCount] = lcd.data;
            initRs[byteCount]  = lcd.rs;
         end
         byteCount++;
         if (lcd.rs) begin
            panel[cursor] = lcd.data;
            if (cursor == 31) refreshDone++;
            cursor = (cursor + 1) % 32;
            rowChars++;
         end else begin
            if (lcd.data == 8'hC0 && (lastCmd != 8'h80 || rowChars != 16)) begin
               $display("row 2 address came after %0d row 1 characters", rowChars);
               framingErrs++;
            end
            if (lcd.data == 8'h80 && row1Cmds > 0 && (lastCmd != 8'hC0 || rowChars != 16)) begin
               $display("row 1 address came after %0d row 2 characters", rowChars);
               framingErrs++;
            end
            if (lcd.data == 8'h80) begin
               cursor = 0;
               row1Cmds++;
            end
            if (lcd.data == 8'hC0) cursor = 16;
            lastCmd  = lcd.data;
            rowChars = 0;
         end
      end
      enPrev = lcd.en;
   end

   // --------------------
   // Compare tasks
   task automatic checkCommand(string name, lcdChar_t expected, lcdChar_t actual);
      if (actual !== expected) begin
         $display("mismatch %s: expected %02h, actual %02h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic checkRow(string name, rowText_t expected, rowText_t actual);
      if (actual !== expected) begin
         $display("mismatch %s: expected \"%s\", actual \"%s\"", name, expected, actual);
         errors++;
      end
   endtask

   task automatic reportTest(string name, int errorsBefore);
      if (errors == errorsBefore) begin
         $display("pass %s", name);
         passCount++;
      end else begin
         $display("fail %s", name);
         failCount++;
      end
   endtask

   // --------------------
   // Expected values from the scaling and layout rules
   function automatic int centiVolts(adcSample_t code);
      return (int'(code) * 330) / 4095;
   endfunction

   function automatic int degrees(pulseWidth_t width);
      longint deg;
      deg = (longint'(width) * 180) / 2500;
      return (deg > 180) ? 180 : int'(deg);
   endfunction

   function automatic rowText_t toRow(string text);
      rowText_t row;
      for (int i = 0; i < 16; i++) begin
         row[i] = (i < text.len()) ? text[i] : 8'h20;   // Pad with spaces
      end
      return row;
   endfunction

   function automatic rowText_t panelRow(int base);
      rowText_t row;
      for (int i = 0; i < 16; i++) begin
         row[i] = panel[base + i];
      end
      return row;
   endfunction

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState;
   endfunction

   function automatic adcSample_t randAdc();
      return adcSample_t'(nextRand() >> 20);
   endfunction

   function automatic pulseWidth_t randPulse();
      return nextRand() % 32'd3000;   // Reaches past full scale
   endfunction

   task automatic addEntry(int idx, string name, logic angle, sweepFlags_t sw, adcSample_t aNow,
                           adcSample_t aMax, servoPair_t pNow, servoPair_t pMax);
      stimEntry_t e;
      int cvMax;
      int cvNow;
      cvMax = centiVolts(aMax);
      cvNow = centiVolts(aNow);
      e = '{angle, sw, aNow, aMax, pNow, pMax, '0, '0};
      if (angle) begin
         e.row1 = toRow($sformatf("H: %03dD V: %03dD ", degrees(pMax.horiz), degrees(pMax.vert)));
         e.row2 = toRow($sformatf("H: %03dD V: %03dD ", degrees(pNow.horiz), degrees(pNow.vert)));
      end else begin
         if (sw != 3'b000) e.row1 = toRow("CALIBRATING");
         else e.row1 = toRow("MANUAL CTRL");
         e.row2 = toRow($sformatf("M: %0d.%02d V: %0d.%02d ",
                                  cvMax / 100, cvMax % 100, cvNow / 100, cvNow % 100));
      end
      stimTable[idx] = e;
      testName[idx]  = name;
   endtask

   task automatic buildTable();
      addEntry(0, "manual_zero", 1'b0, 3'b000, 12'd0, 12'd0, 64'd0, 64'd0);
      addEntry(1, "manual_full", 1'b0, 3'b000, 12'd4095, 12'd4095, 64'd0, 64'd0);
      addEntry(2, "calib_horiz", 1'b0, 3'b100, randAdc(), randAdc(), 64'd0, 64'd0);
      addEntry(3, "calib_vert", 1'b0, 3'b010, randAdc(), randAdc(), 64'd0, 64'd0);
      addEntry(4, "calib_manual", 1'b0, 3'b001, 12'd4095, randAdc(), 64'd0, 64'd0);
      addEntry(5, "volt_random", 1'b0, 3'b000, randAdc(), randAdc(), 64'd0, 64'd0);
      addEntry(6, "angle_mid", 1'b1, 3'b000, 12'd0, 12'd0,
               {32'd1250, 32'd1000}, {32'd2500, 32'd0});
      addEntry(7, "angle_over", 1'b1, 3'b000, 12'd0, 12'd0,
               {32'd3000, 32'hFFFF_FFFF}, {32'd2501, 32'd2499});
      addEntry(8, "angle_priority", 1'b1, 3'b111, randAdc(), randAdc(),
               {randPulse(), randPulse()}, {randPulse(), randPulse()});
      addEntry(9, "angle_random", 1'b1, 3'b000, randAdc(), randAdc(),
               {randPulse(), randPulse()}, {randPulse(), randPulse()});
   endtask

   // --------------------
   // Main sequence
   initial begin
      int errorsBefore;
      int snapRow1;
      int snapDone;
      CLK       = 1'b0;
      rst       = 1'b1;
      angleMode = 1'b0;
      sweep     = '0;
      adcNow    = '0;
      adcMax    = '0;
      pulseNow  = '0;
      pulseMax  = '0;
      buildTable();

      repeat (4) @(posedge CLK);
      @(negedge CLK);
      errorsBefore = errors;
      if (lcd.en !== 1'b0 || lcd.rs !== 1'b0) begin
         $display("en or rs not low during reset");
         errors++;
      end
      checkCommand("reset_data", 8'h00, lcd.data);
      reportTest("reset_idle", errorsBefore);
      @(posedge CLK);
      rst <= 1'b0;

      // Four init commands, then the row 1 address
      errorsBefore = errors;
      while (byteCount < 5) @(posedge CLK);
      for (int i = 0; i < 5; i++) begin
         if (initRs[i] !== 1'b0) begin
            $display("init byte %0d sent with rs high", i);
            errors++;
         end
      end
      checkCommand("init_function_set", 8'h38, initLog[0]);
      checkCommand("init_display_on", 8'h0C, initLog[1]);
      checkCommand("init_entry_mode", 8'h06, initLog[2]);
      checkCommand("init_clear", 8'h01, initLog[3]);
      checkCommand("init_row1", 8'h80, initLog[4]);
      reportTest("init_sequence", errorsBefore);

      for (int t = 0; t < NUM_TESTS; t++) begin
         errorsBefore = errors;
         @(posedge CLK);
         angleMode <= stimTable[t].angleMode;
         sweep     <= stimTable[t].sweep;
         adcNow    <= stimTable[t].adcNow;
         adcMax    <= stimTable[t].adcMax;
         pulseNow  <= stimTable[t].pulseNow;
         pulseMax  <= stimTable[t].pulseMax;
         repeat (4) @(posedge CLK);   // Three pipeline stages and a spare cycle
         snapRow1 = row1Cmds;
         while (row1Cmds == snapRow1) @(posedge CLK);
         snapDone = refreshDone;
         while (refreshDone == snapDone) @(posedge CLK);
         checkRow({testName[t], " row 1"}, stimTable[t].row1, panelRow(0));
         checkRow({testName[t], " row 2"}, stimTable[t].row2, panelRow(16));
         reportTest(testName[t], errorsBefore);
      end

      errorsBefore = errors;
      errors += framingErrs;
      reportTest("row_framing", errorsBefore);

      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               passCount + failCount, passCount, failCount, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== valueScaler.sv ====
/* Execute stage with voltage and angle scaling feeding six digit converters */
`timescale 1ns/100ps

module valueScaler import lcdPkg::*; (
   input  logic          CLK,
   input  logic          rst,
   input  dispMode_t     mode,
   input  adcSample_t    adcNow,
   input  adcSample_t    adcMax,
   input  servoPair_t    pulseNow,
   input  servoPair_t    pulseMax,
   output scaledValues_t scaled
);

   dispMode_t  modeQ;   // Lines up with the converter registers
   centiVolt_t maxCv;
   centiVolt_t nowCv;
   angleDeg_t  maxHDeg;
   angleDeg_t  maxVDeg;
   angleDeg_t  nowHDeg;
   angleDeg_t  nowVDeg;
   digits3_t   maxVoltDig;
   digits3_t   nowVoltDig;
   digits3_t   maxHDig;
   digits3_t   maxVDig;
   digits3_t   nowHDig;
   digits3_t   nowVDig;

   // code * 330 / 4095
   function automatic centiVolt_t toCentiVolt(adcSample_t code);
      logic [20:0] prod;
      prod = 21'(code) * 21'(VOLT_FULL_SCALE);
      return centiVolt_t'(prod / 21'(ADC_MAX));
   endfunction

   // width * 180 / 2500 saturating at 180 from full scale up
   function automatic angleDeg_t toAngle(pulseWidth_t width);
      logic [19:0] prod;
      if (width >= PULSE_FULL_SCALE) return angleDeg_t'(ANGLE_RANGE);
      prod = 20'(width) * 20'(ANGLE_RANGE);
      return angleDeg_t'(prod / 20'(PULSE_FULL_SCALE));
   endfunction

   always_comb begin
      maxCv   = toCentiVolt(adcMax);
      nowCv   = toCentiVolt(adcNow);
      maxHDeg = toAngle(pulseMax.horiz);
      maxVDeg = toAngle(pulseMax.vert);
      nowHDeg = toAngle(pulseNow.horiz);
      nowVDeg = toAngle(pulseNow.vert);
   end

   // --------------------
   // Digit converters
   bcdConverter #(.valueT(centiVolt_t)) maxVolt_i (.CLK(CLK), .value(maxCv), .digits(maxVoltDig));
   bcdConverter #(.valueT(centiVolt_t)) nowVolt_i (.CLK(CLK), .value(nowCv), .digits(nowVoltDig));
   bcdConverter #(.valueT(angleDeg_t)) maxH_i (.CLK(CLK), .value(maxHDeg), .digits(maxHDig));
   bcdConverter #(.valueT(angleDeg_t)) maxV_i (.CLK(CLK), .value(maxVDeg), .digits(maxVDig));
   bcdConverter #(.valueT(angleDeg_t)) nowH_i (.CLK(CLK), .value(nowHDeg), .digits(nowHDig));
   bcdConverter #(.valueT(angleDeg_t)) nowV_i (.CLK(CLK), .value(nowVDeg), .digits(nowVDig));

   always_ff @(posedge CLK) begin
      if (rst) modeQ <= modeManual;
      else modeQ <= mode;
   end

   always_comb begin
      scaled.mode    = modeQ;
      scaled.maxVolt = maxVoltDig;
      scaled.nowVolt = nowVoltDig;
      scaled.maxH    = maxHDig;
      scaled.maxV    = maxVDig;
      scaled.nowH    = nowHDig;
      scaled.nowV    = nowVDig;
   end

endmodule
